// File: Bender.yml
package:
  name: pmp_checker

sources:
  - design/pmp_pkg.sv
  - design/pmp_region_match.sv
  - design/pmp_access_check.sv
  - design/pmp_checker.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/pmp_checker_tb.sv

// File: design/pmp_access_check.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_access_check
  import pmp_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  logic        match_valid_i,
  input  pmp_match_t  match_i,
  output logic        result_valid_o,
  output pmp_result_t result_o
);

  logic        priv_m;
  logic        priv_u;
  logic [3:0]  lrwx;
  logic        rwx_bit;
  logic        classic_ok;
  logic        mml_ok;
  logic        nomatch_ok;
  logic        allowed_d;
  pmp_result_t result_d;

  assign priv_m = (match_i.priv == PRIV_LVL_M);
  assign priv_u = (match_i.priv == PRIV_LVL_U);

  // Permission nibble in table order L R W X
  assign lrwx = {match_i.cfg.lock, match_i.cfg.read, match_i.cfg.write, match_i.cfg.exec};

  // ------------------------------------------------------------
  // MML clear, region matched
  // ------------------------------------------------------------

  always_comb begin
    case (match_i.acc)
      PMP_ACC_READ:  rwx_bit = match_i.cfg.read;
      PMP_ACC_WRITE: rwx_bit = match_i.cfg.write;
      PMP_ACC_EXEC:  rwx_bit = match_i.cfg.exec;
      default:       rwx_bit = 1'b0;
    endcase
  end

  // Unlocked regions do not restrict M-mode
  assign classic_ok = priv_m ? (~match_i.cfg.lock | rwx_bit) : (priv_u & rwx_bit);

  // ------------------------------------------------------------
  // MML set, region matched
  // ------------------------------------------------------------

  always_comb begin
    mml_ok = 1'b0;
    case (match_i.acc)
      PMP_ACC_READ: begin
        if (priv_m) begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b1011, 4'b1100,
                                4'b1101, 4'b1110, 4'b1111};
        end else if (priv_u) begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b0100, 4'b0101,
                                4'b0110, 4'b0111, 4'b1111};
        end
      end
      PMP_ACC_WRITE: begin
        if (priv_m) begin
          mml_ok = lrwx inside {4'b0010, 4'b0011, 4'b1110};
        end else if (priv_u) begin
          mml_ok = lrwx inside {4'b0011, 4'b0110, 4'b0111};
        end
      end
      PMP_ACC_EXEC: begin
        // Locked W and WX are shared code regions for both modes
        if (priv_m) begin
          mml_ok = lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101};
        end else if (priv_u) begin
          mml_ok = lrwx inside {4'b0001, 4'b0101, 4'b0111, 4'b1010, 4'b1011};
        end
      end
      default: begin
        mml_ok = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // No match
  // ------------------------------------------------------------

  always_comb begin
    nomatch_ok = 1'b0;
    if (priv_m) begin
      case (match_i.acc)
        PMP_ACC_READ:  nomatch_ok = ~match_i.mseccfg.mmwp;
        PMP_ACC_WRITE: nomatch_ok = ~match_i.mseccfg.mmwp;
        PMP_ACC_EXEC:  nomatch_ok = ~match_i.mseccfg.mmwp & ~match_i.mseccfg.mml;
        default:       nomatch_ok = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------

  always_comb begin
    if (match_i.matched) begin
      allowed_d = match_i.mseccfg.mml ? mml_ok : classic_ok;
    end else begin
      allowed_d = nomatch_ok;
    end
  end

  assign result_d.allowed = allowed_d;
  assign result_d.matched = match_i.matched;
  assign result_d.locked  = match_i.cfg.lock;
  assign result_d.index   = match_i.index;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= match_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (match_valid_i) begin
      result_o <= result_d;
    end
  end

  a_valid_latency: assert property (@(posedge clk) disable iff (reset_i)
    result_valid_o == $past(match_valid_i));

  // U-mode outside every region is always denied
  a_umode_nomatch_denied: assert property (@(posedge clk) disable iff (reset_i)
    match_valid_i && !match_i.matched && (match_i.priv == PRIV_LVL_U)
    |=> !result_o.allowed && !result_o.matched);

endmodule

`default_nettype wire

// File: design/pmp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_checker
  import pmp_pkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  pmp_csr_t    csr_i,
  input  logic        req_valid_i,
  input  pmp_req_t    req_i,
  output logic        result_valid_o,
  output pmp_result_t result_o
);

  // Stage 1 to stage 2
  logic       match_valid;
  pmp_match_t match;

  // ------------------------------------------------------------
  // Stage 1, region lookup
  // ------------------------------------------------------------

  pmp_region_match u_region_match (
    .clk           (clk),
    .reset_i       (reset_i),
    .csr_i         (csr_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .match_valid_o (match_valid),
    .match_o       (match)
  );

  // ------------------------------------------------------------
  // Stage 2, permission rules
  // ------------------------------------------------------------

  pmp_access_check u_access_check (
    .clk            (clk),
    .reset_i        (reset_i),
    .match_valid_i  (match_valid),
    .match_i        (match),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// File: design/pmp_pkg.sv
`default_nettype none

package pmp_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------

  localparam int PMP_NUM_REGIONS = 4;
  localparam int PMP_IDX_W       = 2;
  localparam int PMP_ADDR_W      = 34;

  // Word address used for matching, granularity fixed at 4 bytes
  localparam int PMP_WORD_W      = PMP_ADDR_W - 2;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_acc_e;

  // ------------------------------------------------------------
  // CSR view
  // ------------------------------------------------------------

  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef struct packed {
    logic mml;
    logic mmwp;
  } mseccfg_t;

  // Address words hold bits 33:2 of the region boundary
  typedef struct packed {
    pmp_cfg_t [PMP_NUM_REGIONS-1:0]                  cfg;
    logic     [PMP_NUM_REGIONS-1:0][PMP_WORD_W-1:0] addr;
    mseccfg_t                                        mseccfg;
  } pmp_csr_t;

  // ------------------------------------------------------------
  // Pipeline payloads
  // ------------------------------------------------------------

  typedef struct packed {
    logic [PMP_ADDR_W-1:0] addr;
    pmp_acc_e              acc;
    priv_lvl_e             priv;
  } pmp_req_t;

  typedef struct packed {
    logic                 matched;
    logic [PMP_IDX_W-1:0] index;
    pmp_cfg_t             cfg;
    pmp_acc_e             acc;
    priv_lvl_e            priv;
    mseccfg_t             mseccfg;
  } pmp_match_t;

  typedef struct packed {
    logic                 allowed;
    logic                 matched;
    logic                 locked;
    logic [PMP_IDX_W-1:0] index;
  } pmp_result_t;

endpackage

`default_nettype wire

// File: design/pmp_region_match.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_region_match
  import pmp_pkg::*;
(
  input  logic       clk,
  input  logic       reset_i,
  input  pmp_csr_t   csr_i,
  input  logic       req_valid_i,
  input  pmp_req_t   req_i,
  output logic       match_valid_o,
  output pmp_match_t match_o
);

  logic [PMP_WORD_W-1:0]      req_word;
  logic [PMP_NUM_REGIONS-1:0] region_hit;
  logic                       hit_any;
  logic [PMP_IDX_W-1:0]       hit_idx;
  pmp_match_t                 match_d;

  assign req_word = req_i.addr[PMP_ADDR_W-1:2];

  // ------------------------------------------------------------
  // Per-region address match
  // ------------------------------------------------------------

  for (genvar r = 0; r < PMP_NUM_REGIONS; r++) begin : g_region
    logic [PMP_WORD_W-1:0] tor_lo;
    logic [PMP_WORD_W-1:0] napot_mask;
    logic                  hit;

    // TOR lower bound comes from the previous region's word
    if (r == 0) begin : g_first
      assign tor_lo = '0;
    end else begin : g_chain
      assign tor_lo = csr_i.addr[r-1];
    end

    // Clears every bit up to and including the lowest zero of the word
    assign napot_mask = ~(csr_i.addr[r] ^ (csr_i.addr[r] + 1'b1));

    always_comb begin
      case (csr_i.cfg[r].mode)
        PMP_MODE_NA4: begin
          hit = (req_word == csr_i.addr[r]);
        end
        PMP_MODE_TOR: begin
          hit = (tor_lo <= req_word) && (req_word < csr_i.addr[r]);
        end
        PMP_MODE_NAPOT: begin
          hit = ((req_word & napot_mask) == (csr_i.addr[r] & napot_mask));
        end
        default: begin
          hit = 1'b0;
        end
      endcase
    end

    assign region_hit[r] = hit;
  end

  // ------------------------------------------------------------
  // Priority, lowest index wins
  // ------------------------------------------------------------

  assign hit_any = |region_hit;

  always_comb begin
    casez (region_hit)
      4'b???1: hit_idx = 2'd0;
      4'b??10: hit_idx = 2'd1;
      4'b?100: hit_idx = 2'd2;
      4'b1000: hit_idx = 2'd3;
      default: hit_idx = 2'd0;
    endcase
  end

  always_comb begin
    match_d.matched = hit_any;
    match_d.index   = hit_idx;
    if (hit_any) begin
      match_d.cfg = csr_i.cfg[hit_idx];
    end else begin
      match_d.cfg = '0;
    end
    match_d.acc     = req_i.acc;
    match_d.priv    = req_i.priv;
    match_d.mseccfg = csr_i.mseccfg;
  end

  // ------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset_i) begin
      match_valid_o <= 1'b0;
    end else begin
      match_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      match_o <= match_d;
    end
  end

  // A reported match never points at a disabled region
  a_match_not_off: assert property (@(posedge clk) disable iff (reset_i)
    req_valid_i && hit_any |=> match_o.matched && (match_o.cfg.mode != PMP_MODE_OFF));

endmodule

`default_nettype wire

// File: sources.f
+incdir+verification
design/pmp_pkg.sv
design/pmp_region_match.sv
design/pmp_access_check.sv
design/pmp_checker.sv
verification/pmp_checker_tb.sv

// File: verification/pmp_checker_tb_table.svh
`ifndef PMP_CHECKER_TB_TABLE_SVH
`define PMP_CHECKER_TB_TABLE_SVH

// Row columns: byte address, access, privilege, then the expected
// allowed, matched, locked and region index
task automatic load_table();
  // TOR chain, NA4 and a 32-byte NAPOT with MML and MMWP clear
  tbl_csr = '0;
  set_region(0, make_cfg(1'b1, PMP_MODE_TOR, 3'b100), 32'h0000_0100);
  set_region(1, make_cfg(1'b0, PMP_MODE_TOR, 3'b000), 32'h0000_0200);
  set_region(2, make_cfg(1'b0, PMP_MODE_NA4, 3'b110), 32'h0000_0300);
  set_region(3, make_cfg(1'b1, PMP_MODE_NAPOT, 3'b001), 32'h0000_0403);
  add_row(34'h0000, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 1, 0);
  add_row(34'h03FC, PMP_ACC_WRITE, PRIV_LVL_M, 0, 1, 1, 0);
  add_row(34'h0400, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 0, 1);
  add_row(34'h0400, PMP_ACC_READ,  PRIV_LVL_U, 0, 1, 0, 1);
  add_row(34'h07FC, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 0, 1);
  add_row(34'h0800, PMP_ACC_READ,  PRIV_LVL_M, 1, 0, 0, 0);
  add_row(34'h0800, PMP_ACC_READ,  PRIV_LVL_U, 0, 0, 0, 0);
  add_row(34'h0800, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 0, 0, 0);
  add_row(34'h0C00, PMP_ACC_WRITE, PRIV_LVL_U, 1, 1, 0, 2);
  add_row(34'h0C00, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 1, 0, 2);
  add_row(34'h0C04, PMP_ACC_READ,  PRIV_LVL_U, 0, 0, 0, 0);
  add_row(34'h0FFC, PMP_ACC_WRITE, PRIV_LVL_M, 1, 0, 0, 0);
  add_row(34'h1000, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 3);
  add_row(34'h101C, PMP_ACC_READ,  PRIV_LVL_M, 0, 1, 1, 3);
  add_row(34'h1010, PMP_ACC_EXEC,  PRIV_LVL_U, 1, 1, 1, 3);
  add_row(34'h1020, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 0, 0, 0);

  // Overlapping NAPOT regions, an OFF region and MMWP set
  tbl_csr = '0;
  tbl_csr.mseccfg.mmwp = 1'b1;
  set_region(0, make_cfg(1'b1, PMP_MODE_NAPOT, 3'b110), 32'h0000_1001);
  set_region(1, make_cfg(1'b1, PMP_MODE_NAPOT, 3'b001), 32'h0000_10FF);
  set_region(2, make_cfg(1'b0, PMP_MODE_OFF, 3'b111), 32'h0000_1000);
  set_region(3, make_cfg(1'b0, PMP_MODE_TOR, 3'b100), 32'h0000_2000);
  add_row(34'h4000, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 1, 0);
  add_row(34'h400C, PMP_ACC_EXEC,  PRIV_LVL_M, 0, 1, 1, 0);
  add_row(34'h4010, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 1);
  add_row(34'h47FC, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 1);
  add_row(34'h4800, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 1, 0, 3);
  add_row(34'h4800, PMP_ACC_READ,  PRIV_LVL_U, 1, 1, 0, 3);
  add_row(34'h4800, PMP_ACC_WRITE, PRIV_LVL_M, 1, 1, 0, 3);
  add_row(34'h8000, PMP_ACC_READ,  PRIV_LVL_M, 0, 0, 0, 0);
  add_row(34'h8000, PMP_ACC_EXEC,  PRIV_LVL_M, 0, 0, 0, 0);
  add_row(34'h3FFC, PMP_ACC_WRITE, PRIV_LVL_M, 0, 0, 0, 0);

  // MML set, MMWP clear, regions W, LRW, LW and RX
  tbl_csr = '0;
  tbl_csr.mseccfg.mml = 1'b1;
  set_region(0, lrwx_cfg(4'b0010), 32'h0000_0010);
  set_region(1, lrwx_cfg(4'b1110), 32'h0000_0011);
  set_region(2, lrwx_cfg(4'b1010), 32'h0000_0012);
  set_region(3, lrwx_cfg(4'b0101), 32'h0000_0013);
  add_row(34'h0040, PMP_ACC_READ,  PRIV_LVL_U, 1, 1, 0, 0);
  add_row(34'h0040, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 0, 0);
  add_row(34'h0040, PMP_ACC_WRITE, PRIV_LVL_U, 0, 1, 0, 0);
  add_row(34'h0040, PMP_ACC_WRITE, PRIV_LVL_M, 1, 1, 0, 0);
  add_row(34'h0040, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 1, 0, 0);
  add_row(34'h0044, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 1, 1);
  add_row(34'h0044, PMP_ACC_WRITE, PRIV_LVL_M, 1, 1, 1, 1);
  add_row(34'h0044, PMP_ACC_READ,  PRIV_LVL_U, 0, 1, 1, 1);
  add_row(34'h0044, PMP_ACC_EXEC,  PRIV_LVL_M, 0, 1, 1, 1);
  add_row(34'h0048, PMP_ACC_EXEC,  PRIV_LVL_U, 1, 1, 1, 2);
  add_row(34'h0048, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 2);
  add_row(34'h0048, PMP_ACC_READ,  PRIV_LVL_U, 0, 1, 1, 2);
  add_row(34'h0048, PMP_ACC_READ,  PRIV_LVL_M, 0, 1, 1, 2);
  add_row(34'h004C, PMP_ACC_EXEC,  PRIV_LVL_U, 1, 1, 0, 3);
  add_row(34'h004C, PMP_ACC_READ,  PRIV_LVL_U, 1, 1, 0, 3);
  add_row(34'h004C, PMP_ACC_EXEC,  PRIV_LVL_M, 0, 1, 0, 3);
  add_row(34'h0080, PMP_ACC_READ,  PRIV_LVL_M, 1, 0, 0, 0);
  add_row(34'h0080, PMP_ACC_EXEC,  PRIV_LVL_M, 0, 0, 0, 0);
  add_row(34'h0080, PMP_ACC_WRITE, PRIV_LVL_U, 0, 0, 0, 0);

  // MML and MMWP set, regions LX, LRWX, RWX and LRX
  tbl_csr = '0;
  tbl_csr.mseccfg.mml  = 1'b1;
  tbl_csr.mseccfg.mmwp = 1'b1;
  set_region(0, lrwx_cfg(4'b1001), 32'h0000_0010);
  set_region(1, lrwx_cfg(4'b1111), 32'h0000_0011);
  set_region(2, lrwx_cfg(4'b0111), 32'h0000_0012);
  set_region(3, lrwx_cfg(4'b1101), 32'h0000_0013);
  add_row(34'h0040, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 0);
  add_row(34'h0040, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 1, 1, 0);
  add_row(34'h0040, PMP_ACC_READ,  PRIV_LVL_M, 0, 1, 1, 0);
  add_row(34'h0044, PMP_ACC_READ,  PRIV_LVL_U, 1, 1, 1, 1);
  add_row(34'h0044, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 1, 1);
  add_row(34'h0044, PMP_ACC_WRITE, PRIV_LVL_M, 0, 1, 1, 1);
  add_row(34'h0048, PMP_ACC_WRITE, PRIV_LVL_U, 1, 1, 0, 2);
  add_row(34'h0048, PMP_ACC_EXEC,  PRIV_LVL_U, 1, 1, 0, 2);
  add_row(34'h0048, PMP_ACC_WRITE, PRIV_LVL_M, 0, 1, 0, 2);
  add_row(34'h004C, PMP_ACC_EXEC,  PRIV_LVL_M, 1, 1, 1, 3);
  add_row(34'h004C, PMP_ACC_READ,  PRIV_LVL_M, 1, 1, 1, 3);
  add_row(34'h004C, PMP_ACC_EXEC,  PRIV_LVL_U, 0, 1, 1, 3);
  add_row(34'h0080, PMP_ACC_READ,  PRIV_LVL_M, 0, 0, 0, 0);
  add_row(34'h0080, PMP_ACC_READ,  PRIV_LVL_U, 0, 0, 0, 0);
endtask

`endif

// File: verification/pmp_checker_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_checker_tb
  import pmp_pkg::*;
();

  localparam int CLK_HALF       = 2;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 50;

  logic        clk;
  logic        reset_i;
  pmp_csr_t    csr_i;
  logic        req_valid_i;
  pmp_req_t    req_i;
  logic        result_valid_o;
  pmp_result_t result_o;

  typedef struct packed {
    pmp_csr_t    csr;
    pmp_req_t    req;
    pmp_result_t exp;
  } vec_t;

  vec_t        vec_q[$];
  pmp_result_t exp_q[$];
  pmp_csr_t    tbl_csr;
  logic [1:0]  valid_pipe;
  int          wait_cycles;

  pmp_checker u_pmp_checker (
    .clk            (clk),
    .reset_i        (reset_i),
    .csr_i          (csr_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ------------------------------------------------------------
  // Table helpers
  // ------------------------------------------------------------

  // rwx is ordered R W X
  function automatic pmp_cfg_t make_cfg(input logic lock, input pmp_mode_e mode,
                                        input logic [2:0] rwx);
    pmp_cfg_t cfg;
    cfg.lock  = lock;
    cfg.mode  = mode;
    cfg.read  = rwx[2];
    cfg.write = rwx[1];
    cfg.exec  = rwx[0];
    return cfg;
  endfunction

  // NA4 region from an L R W X nibble
  function automatic pmp_cfg_t lrwx_cfg(input logic [3:0] lrwx);
    return make_cfg(lrwx[3], PMP_MODE_NA4, lrwx[2:0]);
  endfunction

  task automatic set_region(input int r, input pmp_cfg_t cfg, input logic [31:0] word);
    tbl_csr.cfg[r]  = cfg;
    tbl_csr.addr[r] = word;
  endtask

  task automatic add_row(input logic [PMP_ADDR_W-1:0] addr, input pmp_acc_e acc,
                         input priv_lvl_e priv, input logic allowed, input logic matched,
                         input logic locked, input logic [PMP_IDX_W-1:0] index);
    vec_t v;
    v.csr         = tbl_csr;
    v.req.addr    = addr;
    v.req.acc     = acc;
    v.req.priv    = priv;
    v.exp.allowed = allowed;
    v.exp.matched = matched;
    v.exp.locked  = locked;
    v.exp.index   = index;
    vec_q.push_back(v);
  endtask

  `include "pmp_checker_tb_table.svh"

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic string result_text(input pmp_result_t res);
    return $sformatf("allowed=%b matched=%b locked=%b index=%0d",
                     res.allowed, res.matched, res.locked, res.index);
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Error at time %0t: %s expected %b, got %b",
                               $time, name, exp, act));
    end
  endtask

  task automatic check_result(input string name, input pmp_result_t exp,
                              input pmp_result_t act);
    if (act !== exp) begin
      report_failure($sformatf("Error at time %0t: %s expected %s, got %s",
                               $time, name, result_text(exp), result_text(act)));
    end
  endtask

  // Two register stages between request and result
  always @(posedge clk) begin
    if (reset_i) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[0], req_valid_i};
    end
  end

  always @(negedge clk) begin : monitor
    pmp_result_t exp_res;
    if (!reset_i) begin
      check_bit("result_valid_o", valid_pipe[1], result_valid_o);
      if (result_valid_o) begin
        exp_res = exp_q.pop_front();
        check_result("result_o", exp_res, result_o);
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    csr_i       = '0;
    tbl_csr     = '0;
    wait_cycles = 0;
    load_table();

    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;

    foreach (vec_q[i]) begin
      // An idle cycle now and then between requests
      if (i % 8 == 7) begin
        @(posedge clk);
        req_valid_i <= 1'b0;
      end
      @(posedge clk);
      csr_i       <= vec_q[i].csr;
      req_i       <= vec_q[i].req;
      req_valid_i <= 1'b1;
      exp_q.push_back(vec_q[i].exp);
    end
    @(posedge clk);
    req_valid_i <= 1'b0;

    while (exp_q.size() != 0) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT_CYCLES) begin
        report_failure($sformatf("Timed out with %0d results still outstanding",
                                 exp_q.size()));
      end
    end

    // Stray pulses would show up here
    repeat (4) @(posedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
